//--- rtl/taylor_pkg.sv
`default_nettype none

package taylor_pkg;

	localparam int sample_width = 19; // Q1.17 input
	localparam int result_width = 28;
	localparam int frac_bits = 17;
	localparam int terms = 8;
	localparam int tag_width = 8;

	// full product width before rescaling
	localparam int prod_width = result_width + sample_width;

	localparam int one_q = 1 << frac_bits;

	// sine series up to x^7, highest power first
	// even powers are zero but still cost a Horner step
	localparam logic signed [result_width-1:0] coef [terms] = '{
		result_width'(-(one_q / 5040)), // x^7
		result_width'(0),
		result_width'(one_q / 120), // x^5
		result_width'(0),
		result_width'(-(one_q / 6)), // x^3
		result_width'(0),
		result_width'(one_q), // x
		result_width'(0)
	};

	typedef enum logic [1:0] {
		st_idle,
		st_run,
		st_done
	} core_state_t;

endpackage

`default_nettype wire

//--- rtl/series_core.sv
`timescale 1ns/1ps
`default_nettype none

module series_core (
	input logic clk,
	input logic hold,
	input logic load,
	input logic signed [taylor_pkg::sample_width-1:0] sample,
	input logic [taylor_pkg::tag_width-1:0] load_tag,
	input logic grant,
	output logic idle,
	output logic done,
	output logic signed [taylor_pkg::result_width-1:0] result,
	output logic [taylor_pkg::tag_width-1:0] tag
);

	localparam int step_width = $clog2(taylor_pkg::terms);

	taylor_pkg::core_state_t state;
	logic [step_width-1:0] step;

	logic signed [taylor_pkg::sample_width-1:0] x;
	logic signed [taylor_pkg::result_width-1:0] acc;
	logic signed [taylor_pkg::prod_width-1:0] product;
	logic signed [taylor_pkg::prod_width-1:0] scaled;
	logic signed [taylor_pkg::result_width-1:0] horner;

	// one multiply-add per clock
	assign product = taylor_pkg::prod_width'(acc) * taylor_pkg::prod_width'(x);
	assign scaled = product >>> taylor_pkg::frac_bits;
	assign horner = $signed(scaled[taylor_pkg::result_width-1:0]) + taylor_pkg::coef[step];

	assign idle = !hold && state == taylor_pkg::st_idle;
	assign done = state == taylor_pkg::st_done;
	assign result = acc;

	// terms is a power of two, so step wraps to zero after the last coefficient
	always_ff @(posedge clk) begin
		if (hold) begin
			state <= taylor_pkg::st_idle;
			step <= '0;
		end else begin
			case (state)
				taylor_pkg::st_idle: begin
					if (load) begin
						state <= taylor_pkg::st_run;
						step <= step_width'(1);
					end
				end
				taylor_pkg::st_run: begin
					if (step == '0)
						state <= taylor_pkg::st_done; // extra cycle, done lands at terms
					else
						step <= step + 1'b1;
				end
				taylor_pkg::st_done: begin
					if (grant)
						state <= taylor_pkg::st_idle;
				end
				default: state <= taylor_pkg::st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (load && idle) begin
			x <= sample;
			tag <= load_tag;
			acc <= taylor_pkg::coef[0];
		end else if (state == taylor_pkg::st_run && step != '0) begin
			acc <= horner;
		end
	end

endmodule

`default_nettype wire

//--- rtl/reset_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module reset_sequencer #(
	parameter int NUM_CORES = 4,
	parameter int RELEASE_GAP = 22
) (
	input logic clk,
	input logic reset,
	output logic [NUM_CORES-1:0] core_hold
);

	localparam int idx_width = $clog2(NUM_CORES + 1);
	localparam int cnt_width = $clog2(RELEASE_GAP + 1);

	logic [idx_width-1:0] idx; // next core to let go
	logic [cnt_width-1:0] cnt;
	logic active;

	assign active = idx < idx_width'(NUM_CORES);

	always_ff @(posedge clk) begin
		if (reset) begin
			core_hold <= '1;
			idx <= '0;
			cnt <= '0;
		end else if (active) begin
			if (cnt == '0)
				core_hold <= core_hold & ~(NUM_CORES'(1) << idx);
			if (cnt == cnt_width'(RELEASE_GAP - 1)) begin
				cnt <= '0;
				idx <= idx + 1'b1;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
		// parked once idx reaches NUM_CORES
	end

endmodule

`default_nettype wire

//--- rtl/sample_dispatcher.sv
`timescale 1ns/1ps
`default_nettype none

module sample_dispatcher #(
	parameter int NUM_CORES = 4
) (
	input logic clk,
	input logic reset,
	input logic sample_valid,
	input logic [NUM_CORES-1:0] core_idle,
	output logic ready,
	output logic [NUM_CORES-1:0] core_load,
	output logic [taylor_pkg::tag_width-1:0] load_tag
);

	localparam int ptr_width = $clog2(NUM_CORES);

	logic [ptr_width-1:0] ptr;
	logic [ptr_width-1:0] sel;
	logic [ptr_width:0] cand;
	logic found;
	logic accept;

	// first idle core at or after ptr
	always_comb begin
		found = 1'b0;
		sel = ptr;
		cand = '0;
		for (int k = 0; k < NUM_CORES; k++) begin
			cand = (ptr_width + 1)'(ptr) + (ptr_width + 1)'(k);
			if (cand >= (ptr_width + 1)'(NUM_CORES))
				cand = cand - (ptr_width + 1)'(NUM_CORES);
			if (!found && core_idle[cand[ptr_width-1:0]]) begin
				found = 1'b1;
				sel = cand[ptr_width-1:0];
			end
		end
	end

	assign ready = |core_idle;
	assign accept = sample_valid && found; // strobes while not ready are dropped
	assign core_load = accept ? NUM_CORES'(1) << sel : '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			ptr <= '0;
			load_tag <= '0;
		end else if (accept) begin
			ptr <= (sel == ptr_width'(NUM_CORES - 1)) ? '0 : sel + 1'b1;
			load_tag <= load_tag + 1'b1; // wraps
		end
	end

endmodule

`default_nettype wire

//--- rtl/result_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module result_arbiter #(
	parameter int NUM_CORES = 4
) (
	input logic clk,
	input logic reset,
	input logic [NUM_CORES-1:0] core_done,
	input logic signed [taylor_pkg::result_width-1:0] core_result [NUM_CORES],
	input logic [taylor_pkg::tag_width-1:0] core_tag [NUM_CORES],
	output logic [NUM_CORES-1:0] core_grant,
	output logic result_valid,
	output logic signed [taylor_pkg::result_width-1:0] result,
	output logic [taylor_pkg::tag_width-1:0] result_tag,
	output logic [$clog2(NUM_CORES)-1:0] result_core
);

	localparam int ptr_width = $clog2(NUM_CORES);

	logic [ptr_width-1:0] ptr;
	logic [ptr_width-1:0] sel;
	logic [ptr_width:0] cand;
	logic found;

	always_comb begin
		found = 1'b0;
		sel = ptr;
		cand = '0;
		for (int k = 0; k < NUM_CORES; k++) begin
			cand = (ptr_width + 1)'(ptr) + (ptr_width + 1)'(k);
			if (cand >= (ptr_width + 1)'(NUM_CORES))
				cand = cand - (ptr_width + 1)'(NUM_CORES);
			if (!found && core_done[cand[ptr_width-1:0]]) begin
				found = 1'b1;
				sel = cand[ptr_width-1:0];
			end
		end
	end

	// granted core drops done on the next edge, so this is a single pulse
	assign core_grant = found ? NUM_CORES'(1) << sel : '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			ptr <= '0;
			result_valid <= 1'b0;
		end else begin
			result_valid <= found;
			if (found)
				ptr <= (sel == ptr_width'(NUM_CORES - 1)) ? '0 : sel + 1'b1;
		end
	end

	// shared bus payload
	always_ff @(posedge clk) begin
		if (found) begin
			result <= core_result[sel];
			result_tag <= core_tag[sel];
			result_core <= sel;
		end
	end

endmodule

`default_nettype wire

//--- rtl/taylor_array.sv
`timescale 1ns/1ps
`default_nettype none

module taylor_array #(
	parameter int NUM_CORES = 4,
	parameter int RELEASE_GAP = 22
) (
	input logic clk,
	input logic reset,
	input logic sample_valid,
	input logic signed [taylor_pkg::sample_width-1:0] sample,
	output logic ready,
	output logic result_valid,
	output logic signed [taylor_pkg::result_width-1:0] result,
	output logic [taylor_pkg::tag_width-1:0] result_tag,
	output logic [$clog2(NUM_CORES)-1:0] result_core
);

	logic [NUM_CORES-1:0] core_hold;
	logic [NUM_CORES-1:0] core_idle;
	logic [NUM_CORES-1:0] core_done;
	logic [NUM_CORES-1:0] core_load;
	logic [NUM_CORES-1:0] core_grant;
	logic [taylor_pkg::tag_width-1:0] load_tag;
	logic signed [taylor_pkg::result_width-1:0] core_result [NUM_CORES];
	logic [taylor_pkg::tag_width-1:0] core_tag [NUM_CORES];

	reset_sequencer #(
		.NUM_CORES(NUM_CORES),
		.RELEASE_GAP(RELEASE_GAP)
	) reset_sequencer_i (
		.clk(clk),
		.reset(reset),
		.core_hold(core_hold)
	);

	sample_dispatcher #(
		.NUM_CORES(NUM_CORES)
	) sample_dispatcher_i (
		.clk(clk),
		.reset(reset),
		.sample_valid(sample_valid),
		.core_idle(core_idle),
		.ready(ready),
		.core_load(core_load),
		.load_tag(load_tag)
	);

	// sample is broadcast, only the loaded core captures it
	for (genvar i = 0; i < NUM_CORES; i++) begin : g_core
		series_core series_core_i (
			.clk(clk),
			.hold(core_hold[i]),
			.load(core_load[i]),
			.sample(sample),
			.load_tag(load_tag),
			.grant(core_grant[i]),
			.idle(core_idle[i]),
			.done(core_done[i]),
			.result(core_result[i]),
			.tag(core_tag[i])
		);
	end

	result_arbiter #(
		.NUM_CORES(NUM_CORES)
	) result_arbiter_i (
		.clk(clk),
		.reset(reset),
		.core_done(core_done),
		.core_result(core_result),
		.core_tag(core_tag),
		.core_grant(core_grant),
		.result_valid(result_valid),
		.result(result),
		.result_tag(result_tag),
		.result_core(result_core)
	);

endmodule

`default_nettype wire

//--- tests/taylor_array_properties.sv
`timescale 1ns/1ps
`default_nettype none

module taylor_array_properties #(
	parameter int NUM_CORES = 4
) (
	input logic clk,
	input logic reset,
	input logic ready,
	input logic result_valid,
	input logic [NUM_CORES-1:0] core_load,
	input logic [NUM_CORES-1:0] core_grant
);

	load_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(core_load))
		else $error("more than one core loaded in the same cycle");

	grant_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(core_grant))
		else $error("more than one core granted in the same cycle");

	// dispatcher must never load while the array reports not ready
	load_needs_ready: assert property (@(posedge clk) disable iff (reset)
		|core_load |-> ready)
		else $error("core loaded while ready was low");

	quiet_after_reset: assert property (@(posedge clk)
		(!reset && $past(reset)) |-> !result_valid)
		else $error("result_valid high in the first cycle after reset");

endmodule

bind taylor_array taylor_array_properties #(
	.NUM_CORES(NUM_CORES)
) taylor_array_properties_i (
	.clk(clk),
	.reset(reset),
	.ready(ready),
	.result_valid(result_valid),
	.core_load(core_load),
	.core_grant(core_grant)
);

`default_nettype wire

//--- tests/taylor_array_tb.sv
`timescale 1ns/1ps
`default_nettype none

module taylor_array_tb;

	localparam int num_cores = 4;
	localparam int release_gap = 22;
	localparam int n_samples = 212; // single, extremes, burst, contention, ignored, tail
	localparam int watchdog_cycles = n_samples * (taylor_pkg::terms + num_cores + 2)
		+ num_cores * release_gap + 200;
	localparam logic [31:0] lfsr_seed = 32'ha3a0_4eae;
	localparam int tag_count = 1 << taylor_pkg::tag_width;

	localparam logic signed [taylor_pkg::sample_width-1:0] half_sample =
		taylor_pkg::sample_width'(1 << (taylor_pkg::frac_bits - 1));
	localparam logic signed [taylor_pkg::sample_width-1:0] max_sample =
		{1'b0, {(taylor_pkg::sample_width - 1){1'b1}}};
	localparam logic signed [taylor_pkg::sample_width-1:0] min_sample =
		{1'b1, {(taylor_pkg::sample_width - 1){1'b0}}};

	logic clk = 1'b0;
	logic reset;
	logic sample_valid;
	logic signed [taylor_pkg::sample_width-1:0] sample;
	logic ready;
	logic result_valid;
	logic signed [taylor_pkg::result_width-1:0] result;
	logic [taylor_pkg::tag_width-1:0] result_tag;
	logic [$clog2(num_cores)-1:0] result_core;

	int cycle = 0;
	int errors = 0;
	int unexpected = 0;
	int missing = 0;
	int accepted = 0;
	int received = 0;
	int last_result_cycle = 0;
	logic [taylor_pkg::tag_width-1:0] last_tag = '0;
	logic [taylor_pkg::tag_width-1:0] next_tag = '0; // tag the DUT should hand out next
	logic [num_cores-1:0] seen_cores = '0;
	logic [31:0] lfsr_state;

	// scoreboard indexed by tag
	bit pending [tag_count];
	logic signed [taylor_pkg::result_width-1:0] expect_val [tag_count];
	int accept_cycle [tag_count];

	taylor_array #(
		.NUM_CORES(num_cores),
		.RELEASE_GAP(release_gap)
	) taylor_array_i (
		.clk(clk),
		.reset(reset),
		.sample_valid(sample_valid),
		.sample(sample),
		.ready(ready),
		.result_valid(result_valid),
		.result(result),
		.result_tag(result_tag),
		.result_core(result_core)
	);

	always #5 clk = ~clk;

	always @(posedge clk) cycle <= cycle + 1;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
	endfunction

	// Horner rule on the shared coefficient table
	function automatic logic signed [taylor_pkg::result_width-1:0] taylor_ref(
		input logic signed [taylor_pkg::sample_width-1:0] x
	);
		logic signed [taylor_pkg::result_width-1:0] acc;
		longint prod;
		acc = taylor_pkg::coef[0];
		for (int k = 1; k < taylor_pkg::terms; k++) begin
			prod = longint'(acc) * longint'(x);
			prod = prod >>> taylor_pkg::frac_bits;
			acc = taylor_pkg::result_width'(prod) + taylor_pkg::coef[k]; // wraps
		end
		return acc;
	endfunction

	task automatic take_bits(input int n, output logic [31:0] bits);
		bits = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = lfsr_step(lfsr_state);
			bits = {bits[30:0], lfsr_state[0]};
		end
	endtask

	task automatic random_sample(output logic signed [taylor_pkg::sample_width-1:0] x);
		logic [31:0] bits;
		take_bits(taylor_pkg::sample_width, bits);
		x = bits[taylor_pkg::sample_width-1:0];
	endtask

	task automatic compare_values(input string name, input logic signed [63:0] expected,
		input logic signed [63:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	// strobe for one cycle; ready at the negedge decides whether the next edge takes it
	task automatic drive_strobe(input logic signed [taylor_pkg::sample_width-1:0] x,
		output bit taken);
		@(posedge clk);
		sample_valid <= 1'b1;
		sample <= x;
		@(negedge clk);
		taken = ready;
		if (ready) begin
			expect_val[next_tag] = taylor_ref(x);
			accept_cycle[next_tag] = cycle + 1;
			pending[next_tag] = 1'b1;
			next_tag = next_tag + 1'b1;
			accepted++;
		end
	endtask

	task automatic offer_sample(input logic signed [taylor_pkg::sample_width-1:0] x);
		bit taken;
		taken = 1'b0;
		while (!taken)
			drive_strobe(x, taken);
	endtask

	task automatic wait_results();
		@(posedge clk);
		sample_valid <= 1'b0;
		while (received < accepted)
			@(negedge clk);
	endtask

	always @(negedge clk) begin
		if (!reset && result_valid) begin
			received++;
			last_result_cycle = cycle;
			last_tag = result_tag;
			seen_cores[result_core] = 1'b1;
			if (!pending[result_tag]) begin
				unexpected++;
				$display("result tag %0d from core %0d was not expected or came twice",
					result_tag, result_core);
			end else begin
				compare_values($sformatf("result_tag_%0d", result_tag),
					expect_val[result_tag], result);
				pending[result_tag] = 1'b0;
			end
		end
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("timeout after %0d cycles with %0d results outstanding",
			watchdog_cycles, accepted - received);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		logic signed [taylor_pkg::sample_width-1:0] x;
		bit taken;
		int n;
		int ignored;
		reset = 1'b1;
		sample_valid = 1'b0;
		sample = '0;
		lfsr_state = lfsr_seed;

		// last pass checks the first cycle with reset low
		for (int i = 0; i < 16; i++) begin
			@(posedge clk);
			if (i == 15)
				reset <= 1'b0;
			@(negedge clk);
			compare_values("reset_ready", 0, ready);
			compare_values("reset_result_valid", 0, result_valid);
		end
		n = 0;
		while (!ready && n < num_cores * release_gap + 1) begin
			@(negedge clk);
			n++;
		end
		compare_values("ready_after_release", 1, ready);

		drive_strobe(half_sample, taken);
		compare_values("single_accept", 1, taken);
		wait_results();
		compare_values("single_tag", 0, last_tag);
		compare_values("single_latency", taylor_pkg::terms + 1,
			last_result_cycle - accept_cycle[0]);

		offer_sample(max_sample);
		offer_sample(min_sample);
		wait_results();

		for (int i = 0; i < 200; i++) begin
			random_sample(x);
			offer_sample(x);
		end
		wait_results();

		// all cores idle here, so four back-to-back strobes fill the array
		for (int i = 0; i < num_cores; i++) begin
			random_sample(x);
			drive_strobe(x, taken);
			compare_values("contention_accept", 1, taken);
		end
		ignored = 0;
		for (int i = 0; i < 4; i++) begin
			random_sample(x);
			drive_strobe(x, taken);
			if (!taken)
				ignored++;
		end
		compare_values("ignored_strobes", 4, ignored);
		random_sample(x);
		offer_sample(x); // tag must follow the last accepted one
		wait_results();

		for (int t = 0; t < tag_count; t++) begin
			if (pending[t]) begin
				missing++;
				$display("no result came back for tag %0d", t);
			end
		end
		compare_values("cores_seen", {num_cores{1'b1}}, seen_cores);

		$display("errors %0d, unexpected tags %0d, missing tags %0d, results %0d",
			errors, unexpected, missing, received);
		if (errors == 0 && unexpected == 0 && missing == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
rtl/taylor_pkg.sv
rtl/series_core.sv
rtl/reset_sequencer.sv
rtl/sample_dispatcher.sv
rtl/result_arbiter.sv
rtl/taylor_array.sv
tests/taylor_array_properties.sv
tests/taylor_array_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the taylor_array testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	-f sim.f --top-module taylor_array_tb -o taylor_array_sim

status=0
./obj_dir/taylor_array_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -eq 0 ] && grep -qx "ALL CHECKS PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi
